/* hdl/twdl_config.svh */
`ifndef TWDL_CONFIG_SVH
`define TWDL_CONFIG_SVH

// sample component width, Q1.17
`define TWDL_DATA_W 18
// coefficient component width, Q2.14
`define TWDL_COEF_W 16
// fraction bits of a coefficient
`define TWDL_FRAC 14
// butterfly lanes, up to radix 5
`define TWDL_LANES 5
// sample buffer depth in entries
`define TWDL_FIFO_DEPTH 32
// phase word, full turn is 2^16
`define TWDL_PHASE_W 16
// cordic iterations
`define TWDL_CORDIC_IT 15

`endif

/* hdl/fft_sample_pkg.sv */
`default_nettype none
`include "twdl_config.svh"

package fft_sample_pkg;

	// one sample component, Q1.17
	typedef logic signed [`TWDL_DATA_W-1:0] data_t;
	// one coefficient component, Q2.14
	typedef logic signed [`TWDL_COEF_W-1:0] coef_comp_t;

	// one lane of the stream
	typedef struct packed {
		data_t re;
		data_t im;
	} sample_t;

	// one twiddle value
	typedef struct packed {
		coef_comp_t re;
		coef_comp_t im;
	} coef_t;

endpackage

`default_nettype wire

/* hdl/twdl_regs_pkg.sv */
`default_nettype none

package twdl_regs_pkg;

	typedef logic [3:0] addr_t;
	// numerator or denominator field
	typedef logic [11:0] ratio_t;
	// radix factor field
	typedef logic [2:0] factor_t;

	// word addresses
	localparam addr_t addr_cfg_frac = 4'h0;
	localparam addr_t addr_cfg_mode = 4'h4;
	localparam addr_t addr_status = 4'h8;
	// denominator position inside cfg_frac
	localparam int den_lsb = 16;

	// values after reset, gives W = 1
	localparam ratio_t rst_numerator = 12'd0;
	localparam ratio_t rst_denominator = 12'd1;
	localparam factor_t rst_factor = 3'd5;

	// special encodings
	localparam ratio_t denom_bypass = 12'd3;
	localparam factor_t factor_radix2 = 3'd2;

endpackage

`default_nettype wire

/* hdl/twdl_apb_regs.sv */
`default_nettype none

module twdl_apb_regs (
	input wire clk,
	input wire rst_n,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [3:0] paddr,
	input wire [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input wire overflow_set,
	input wire coef_ready,
	output twdl_regs_pkg::ratio_t numerator,
	output twdl_regs_pkg::ratio_t denominator,
	output twdl_regs_pkg::factor_t factor,
	output logic restart
);

	localparam int ratio_w = $bits(twdl_regs_pkg::ratio_t);
	localparam int factor_w = $bits(twdl_regs_pkg::factor_t);

	logic access;
	logic wr_en;
	logic rd_en;
	logic hit_frac;
	logic hit_mode;
	logic hit_status;
	logic overflow;

	// access phase only, no wait states
	assign access = psel & penable;
	assign wr_en = access & pwrite;
	assign rd_en = access & ~pwrite;

	assign hit_frac = (paddr == twdl_regs_pkg::addr_cfg_frac);
	assign hit_mode = (paddr == twdl_regs_pkg::addr_cfg_mode);
	assign hit_status = (paddr == twdl_regs_pkg::addr_status);

	assign pready = 1'b1;
	// unmapped address
	assign pslverr = access & ~(hit_frac | hit_mode | hit_status);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			numerator <= twdl_regs_pkg::rst_numerator;
			denominator <= twdl_regs_pkg::rst_denominator;
			factor <= twdl_regs_pkg::rst_factor;
			// held high through reset so a generation starts on release
			restart <= 1'b1;
			overflow <= 1'b0;
		end else begin
			// new config and restart show up on the same edge
			restart <= wr_en & (hit_frac | hit_mode);
			if (wr_en && hit_frac) begin
				numerator <= pwdata[ratio_w-1:0];
				denominator <= pwdata[twdl_regs_pkg::den_lsb +: ratio_w];
			end
			if (wr_en && hit_mode) begin
				factor <= pwdata[factor_w-1:0];
			end
			// sticky, a new drop wins over the clearing read
			if (overflow_set) begin
				overflow <= 1'b1;
			end else if (rd_en && hit_status) begin
				overflow <= 1'b0;
			end
		end
	end

	// read mux
	always_comb begin
		prdata = '0;
		if (hit_frac) begin
			prdata[ratio_w-1:0] = numerator;
			prdata[twdl_regs_pkg::den_lsb +: ratio_w] = denominator;
		end else if (hit_mode) begin
			prdata[factor_w-1:0] = factor;
		end else if (hit_status) begin
			prdata[1:0] = {overflow, coef_ready};
		end
	end

endmodule

`default_nettype wire

/* hdl/twdl_coef_gen.sv */
`default_nettype none
`include "twdl_config.svh"

module twdl_coef_gen (
	input wire clk,
	input wire rst_n,
	input wire restart,
	input wire twdl_regs_pkg::ratio_t numerator,
	input wire twdl_regs_pkg::ratio_t denominator,
	output fft_sample_pkg::coef_t coef [1:`TWDL_LANES-1],
	output logic coef_ready
);

	localparam int cw = `TWDL_COEF_W;
	localparam int frac = `TWDL_FRAC;
	localparam int pw = `TWDL_PHASE_W;
	localparam int rw = $bits(twdl_regs_pkg::ratio_t);
	// cordic vector, a little headroom over a coefficient
	localparam int xw = cw + 2;
	// 16384/1.647, cancels the cordic gain
	localparam logic signed [xw-1:0] x_gain = 9948;
	// 90 degrees in phase units
	localparam logic signed [pw-1:0] quarter = 1 << (pw - 2);

	typedef enum logic [1:0] {
		st_idle,
		st_div,
		st_rot,
		st_pow
	} state_t;

	state_t st;
	logic [4:0] cnt;

	twdl_regs_pkg::ratio_t rem;
	logic [pw-1:0] phase;
	logic [rw:0] rem_sh;
	logic [rw+1:0] rem_sub;
	logic q_bit;

	logic signed [xw-1:0] x, y, x_cur, y_cur, x_nxt, y_nxt, x_init;
	logic signed [pw-1:0] z, z_cur, z_nxt, ang, z_init, atan_cur;
	logic fold;

	fft_sample_pkg::coef_t w1, w2, w3, w4;

	// atan(2^-i) in phase units
	function automatic logic signed [pw-1:0] atan_turn(input logic [4:0] i);
		case (i)
			5'd0: atan_turn = 8192;
			5'd1: atan_turn = 4836;
			5'd2: atan_turn = 2555;
			5'd3: atan_turn = 1297;
			5'd4: atan_turn = 651;
			5'd5: atan_turn = 326;
			5'd6: atan_turn = 163;
			5'd7: atan_turn = 81;
			5'd8: atan_turn = 41;
			5'd9: atan_turn = 20;
			5'd10: atan_turn = 10;
			5'd11: atan_turn = 5;
			5'd12: atan_turn = 3;
			5'd13: atan_turn = 1;
			5'd14: atan_turn = 1;
			default: atan_turn = '0;
		endcase
	endfunction

	// complex product, truncated back to Q2.14
	function automatic fft_sample_pkg::coef_t cmul(
		input fft_sample_pkg::coef_t a,
		input fft_sample_pkg::coef_t b
	);
		logic signed [2*cw-1:0] pr;
		logic signed [2*cw-1:0] pi;
		fft_sample_pkg::coef_t r;
		pr = a.re * b.re - a.im * b.im;
		pi = a.re * b.im + a.im * b.re;
		r.re = pr[frac +: cw];
		r.im = pi[frac +: cw];
		return r;
	endfunction

	// one restoring step per cycle
	assign rem_sh = {rem, 1'b0};
	assign rem_sub = {1'b0, rem_sh} - {2'b00, denominator};
	assign q_bit = ~rem_sub[rw+1];

	// W = exp(-j*theta), so rotate by the negated phase
	assign ang = -$signed(phase);
	// beyond +-90 deg start from -K and take half a turn off
	assign fold = (ang > quarter) || (ang < -quarter);
	assign x_init = fold ? -x_gain : x_gain;
	assign z_init = fold ? {~ang[pw-1], ang[pw-2:0]} : ang;

	always_comb begin
		// first iteration starts from the folded vector
		x_cur = (cnt == '0) ? x_init : x;
		y_cur = (cnt == '0) ? '0 : y;
		z_cur = (cnt == '0) ? z_init : z;
		atan_cur = atan_turn(cnt);
		if (!z_cur[pw-1]) begin
			x_nxt = x_cur - (y_cur >>> cnt);
			y_nxt = y_cur + (x_cur >>> cnt);
			z_nxt = z_cur - atan_cur;
		end else begin
			x_nxt = x_cur + (y_cur >>> cnt);
			y_nxt = y_cur - (x_cur >>> cnt);
			z_nxt = z_cur + atan_cur;
		end
	end

	// control, 1 load + 16 divide + 15 cordic + 4 power cycles
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			st <= st_idle;
			cnt <= '0;
			coef_ready <= 1'b0;
		end else if (restart) begin
			st <= st_div;
			cnt <= '0;
			coef_ready <= 1'b0;
		end else begin
			case (st)
				st_div: begin
					cnt <= (cnt == 5'(pw - 1)) ? '0 : cnt + 5'd1;
					if (cnt == 5'(pw - 1)) st <= st_rot;
				end
				st_rot: begin
					cnt <= (cnt == 5'(`TWDL_CORDIC_IT - 1)) ? '0 : cnt + 5'd1;
					if (cnt == 5'(`TWDL_CORDIC_IT - 1)) st <= st_pow;
				end
				st_pow: begin
					cnt <= (cnt == 5'd3) ? '0 : cnt + 5'd1;
					if (cnt == 5'd3) begin
						st <= st_idle;
						coef_ready <= 1'b1;
					end
				end
				default: cnt <= '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		// phase = numerator * 2^16 / denominator
		if (restart) begin
			rem <= numerator;
			phase <= '0;
		end else if (st == st_div) begin
			rem <= q_bit ? rem_sub[rw-1:0] : rem_sh[rw-1:0];
			phase <= {phase[pw-2:0], q_bit};
		end
		if (st == st_rot) begin
			x <= x_nxt;
			y <= y_nxt;
			z <= z_nxt;
		end
		// power pipeline
		if (st == st_pow) begin
			case (cnt)
				5'd0: begin
					w1.re <= x[cw-1:0];
					w1.im <= y[cw-1:0];
				end
				5'd1: w2 <= cmul(w1, w1);
				5'd2: begin
					w3 <= cmul(w2, w1);
					w4 <= cmul(w2, w2);
				end
				default: begin
					// publish, held until the next restart
					coef[1] <= w1;
					coef[2] <= w2;
					coef[3] <= w3;
					coef[4] <= w4;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/twdl_sample_fifo.sv */
`default_nettype none
`include "twdl_config.svh"

module twdl_sample_fifo (
	input wire clk,
	input wire rst_n,
	input wire push,
	input wire fft_sample_pkg::sample_t wr_data [0:`TWDL_LANES-1],
	input wire pop,
	output fft_sample_pkg::sample_t rd_data [0:`TWDL_LANES-1],
	output logic empty,
	output logic overflow_set
);

	localparam int depth = `TWDL_FIFO_DEPTH;
	localparam int aw = $clog2(depth);

	// one entry holds all five lanes
	fft_sample_pkg::sample_t mem [0:depth-1][0:`TWDL_LANES-1];

	// extra msb tells full from empty
	logic [aw:0] wr_ptr;
	logic [aw:0] rd_ptr;
	logic full;
	logic do_push;
	logic do_pop;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);
	// push to full is dropped
	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	// head entry always visible
	assign rd_data = mem[rd_ptr[aw-1:0]];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			overflow_set <= 1'b0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop) rd_ptr <= rd_ptr + 1'b1;
			// one pulse per lost sample
			overflow_set <= push & full;
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr[aw-1:0]] <= wr_data;
		end
	end

endmodule

`default_nettype wire

/* hdl/twdl_rotator.sv */
`default_nettype none
`include "twdl_config.svh"

module twdl_rotator (
	input wire clk,
	input wire rst_n,
	input wire coef_ready,
	input wire empty,
	output logic pop,
	input wire fft_sample_pkg::sample_t fifo_data [0:`TWDL_LANES-1],
	input wire fft_sample_pkg::coef_t coef [1:`TWDL_LANES-1],
	input wire twdl_regs_pkg::factor_t factor,
	input wire twdl_regs_pkg::ratio_t denominator,
	input wire in_val,
	input wire fft_sample_pkg::data_t din_re [0:`TWDL_LANES-1],
	input wire fft_sample_pkg::data_t din_im [0:`TWDL_LANES-1],
	output logic out_val,
	output fft_sample_pkg::data_t dout_re [0:`TWDL_LANES-1],
	output fft_sample_pkg::data_t dout_im [0:`TWDL_LANES-1]
);

	localparam int lanes = `TWDL_LANES;
	localparam int dw = `TWDL_DATA_W;
	localparam int cw = `TWDL_COEF_W;
	localparam int frac = `TWDL_FRAC;
	// Q1.17 * Q2.14
	localparam int prod_w = dw + cw;
	localparam int acc_w = prod_w + 1;
	localparam int half_lsb = 1 << (frac - 1);
	// lane 0 sees W^0
	localparam fft_sample_pkg::coef_t unity = '{re: cw'(1 << frac), im: '0};

	logic bypass;
	logic radix2;
	logic [2:0] vld;

	fft_sample_pkg::coef_t lane_coef [0:lanes-1];
	fft_sample_pkg::sample_t s1_data [0:lanes-1];
	fft_sample_pkg::coef_t s1_coef [0:lanes-1];
	logic signed [prod_w-1:0] p_rr [0:lanes-1];
	logic signed [prod_w-1:0] p_ii [0:lanes-1];
	logic signed [prod_w-1:0] p_ri [0:lanes-1];
	logic signed [prod_w-1:0] p_ir [0:lanes-1];
	logic signed [acc_w-1:0] acc_re [0:lanes-1];
	logic signed [acc_w-1:0] acc_im [0:lanes-1];

	// round half up at bit 13, back to Q1.17
	function automatic fft_sample_pkg::data_t round_q(input logic signed [acc_w-1:0] acc);
		logic signed [acc_w-1:0] sum;
		sum = acc + half_lsb;
		return sum[frac +: dw];
	endfunction

	assign bypass = (denominator == twdl_regs_pkg::denom_bypass);
	assign radix2 = (factor == twdl_regs_pkg::factor_radix2);

	// take the head whenever W is settled
	assign pop = coef_ready & ~empty;

	always_comb begin
		lane_coef[0] = unity;
		for (int k = 1; k < lanes; k++) begin
			lane_coef[k] = coef[k];
		end
	end

	// valid through the three inner stages
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld <= '0;
		end else begin
			vld <= {vld[1:0], pop};
		end
	end

	always_ff @(posedge clk) begin
		for (int k = 0; k < lanes; k++) begin
			// coef captured with the data, W may change behind it
			if (pop) begin
				s1_data[k] <= fifo_data[k];
				s1_coef[k] <= lane_coef[k];
			end
			// partial products
			p_rr[k] <= s1_data[k].re * s1_coef[k].re;
			p_ii[k] <= s1_data[k].im * s1_coef[k].im;
			p_ri[k] <= s1_data[k].re * s1_coef[k].im;
			p_ir[k] <= s1_data[k].im * s1_coef[k].re;
			// difference and sum
			acc_re[k] <= p_rr[k] - p_ii[k];
			acc_im[k] <= p_ri[k] + p_ir[k];
		end
	end

	// bypass answers one cycle after in_val
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_val <= 1'b0;
		end else begin
			out_val <= bypass ? in_val : vld[2];
		end
	end

	always_ff @(posedge clk) begin
		for (int k = 0; k < lanes; k++) begin
			if (bypass) begin
				dout_re[k] <= din_re[k];
				dout_im[k] <= din_im[k];
			end else if (radix2 && k >= 2) begin
				// radix-2 stage uses lanes 0 and 1 only
				dout_re[k] <= '0;
				dout_im[k] <= '0;
			end else begin
				dout_re[k] <= round_q(acc_re[k]);
				dout_im[k] <= round_q(acc_im[k]);
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/twdl_stage_top.sv */
`default_nettype none
`include "twdl_config.svh"

module twdl_stage_top (
	input wire clk,
	input wire rst_n,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [3:0] paddr,
	input wire [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input wire in_val,
	input wire fft_sample_pkg::data_t din_re [0:`TWDL_LANES-1],
	input wire fft_sample_pkg::data_t din_im [0:`TWDL_LANES-1],
	output logic out_val,
	output fft_sample_pkg::data_t dout_re [0:`TWDL_LANES-1],
	output fft_sample_pkg::data_t dout_im [0:`TWDL_LANES-1]
);

	twdl_regs_pkg::ratio_t numerator;
	twdl_regs_pkg::ratio_t denominator;
	twdl_regs_pkg::factor_t factor;
	logic restart;
	logic coef_ready;
	logic overflow_set;
	logic push;
	logic pop;
	logic empty;
	fft_sample_pkg::coef_t coef [1:`TWDL_LANES-1];
	fft_sample_pkg::sample_t fifo_wr [0:`TWDL_LANES-1];
	fft_sample_pkg::sample_t fifo_rd [0:`TWDL_LANES-1];

	// bypass samples never enter the buffer
	assign push = in_val & (denominator != twdl_regs_pkg::denom_bypass);

	// lanes into buffer words
	always_comb begin
		for (int k = 0; k < `TWDL_LANES; k++) begin
			fifo_wr[k].re = din_re[k];
			fifo_wr[k].im = din_im[k];
		end
	end

	twdl_apb_regs regs_i (
		.clk(clk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.overflow_set(overflow_set),
		.coef_ready(coef_ready),
		.numerator(numerator),
		.denominator(denominator),
		.factor(factor),
		.restart(restart)
	);

	twdl_coef_gen gen_i (
		.clk(clk),
		.rst_n(rst_n),
		.restart(restart),
		.numerator(numerator),
		.denominator(denominator),
		.coef(coef),
		.coef_ready(coef_ready)
	);

	// holds samples while W is recomputed
	twdl_sample_fifo fifo_i (
		.clk(clk),
		.rst_n(rst_n),
		.push(push),
		.wr_data(fifo_wr),
		.pop(pop),
		.rd_data(fifo_rd),
		.empty(empty),
		.overflow_set(overflow_set)
	);

	twdl_rotator rot_i (
		.clk(clk),
		.rst_n(rst_n),
		.coef_ready(coef_ready),
		.empty(empty),
		.pop(pop),
		.fifo_data(fifo_rd),
		.coef(coef),
		.factor(factor),
		.denominator(denominator),
		.in_val(in_val),
		.din_re(din_re),
		.din_im(din_im),
		.out_val(out_val),
		.dout_re(dout_re),
		.dout_im(dout_im)
	);

endmodule

`default_nettype wire

/* tb/tb_clkgen.sv */
`default_nettype none

module tb_clkgen (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int rst_cycles = 3;

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// synchronous reset, released on a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (rst_cycles) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* tb/twdl_checker.sv */
`default_nettype none
`include "twdl_config.svh"

module twdl_checker #(
	parameter int name_w = 96
) (
	input wire clk,
	input wire rst_n,
	input wire check_en,
	input wire [name_w-1:0] test_name,
	input wire [11:0] numerator,
	input wire [11:0] denominator,
	input wire [2:0] factor,
	input wire in_val,
	input wire fft_sample_pkg::data_t din_re [0:`TWDL_LANES-1],
	input wire fft_sample_pkg::data_t din_im [0:`TWDL_LANES-1],
	input wire out_val,
	input wire fft_sample_pkg::data_t dout_re [0:`TWDL_LANES-1],
	input wire fft_sample_pkg::data_t dout_im [0:`TWDL_LANES-1],
	output int pending,
	output int errors,
	output int timeouts
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int lanes = `TWDL_LANES;
	localparam int dw = `TWDL_DATA_W;
	// allowed distance on rotated lanes, in output lsb
	localparam int tol = 4;
	localparam int stall_max = 200;
	localparam int bypass_den = 3;
	localparam int radix2_fac = 2;
	localparam real two_pi = 6.283185307179586;

	// one accepted input with the config it was sent under
	typedef struct packed {
		logic [name_w-1:0] name;
		logic [11:0] num;
		logic [11:0] den;
		logic [2:0] fac;
		logic [lanes*dw-1:0] re;
		logic [lanes*dw-1:0] im;
	} rec_t;

	rec_t exp_q [$];
	rec_t in_rec;
	rec_t out_rec;
	int stall;

	function automatic int abs_diff(input int x, input int y);
		return (x > y) ? x - y : y - x;
	endfunction

	// (a + jb) * exp(-j*ang), rounded to nearest
	function automatic int rotate_part(input int a, input int b, input real ang, input bit want_im);
		real v;
		if (want_im) begin
			v = b * $cos(ang) - a * $sin(ang);
		end else begin
			v = a * $cos(ang) + b * $sin(ang);
		end
		return int'($floor(v + 0.5));
	endfunction

	task automatic compare_part(input logic [name_w-1:0] name, input int k, input string part,
		input int exp_v, input int act_v, input int slack);
		if (abs_diff(exp_v, act_v) > slack) begin
			$display("[ERROR] %s lane %0d %s: expected %0d, actual %0d",
				name, k, part, exp_v, act_v);
			errors++;
		end
	endtask

	task automatic compare_lane(input rec_t r, input int k, input int act_re, input int act_im);
		int a;
		int b;
		int exp_re;
		int exp_im;
		int slack;
		real ang;
		a = $signed(r.re[k*dw +: dw]);
		b = $signed(r.im[k*dw +: dw]);
		exp_re = a;
		exp_im = b;
		slack = 0;
		if (r.den == bypass_den) begin
			// bypass, raw input comes back
			slack = 0;
		end else if (r.fac == radix2_fac && k >= 2) begin
			exp_re = 0;
			exp_im = 0;
		end else if (k != 0) begin
			// lane k sees W^k, angle k*2pi*num/den
			ang = two_pi * r.num * k / r.den;
			exp_re = rotate_part(a, b, ang, 1'b0);
			exp_im = rotate_part(a, b, ang, 1'b1);
			slack = tol;
		end
		compare_part(r.name, k, "re", exp_re, act_re, slack);
		compare_part(r.name, k, "im", exp_im, act_im, slack);
	endtask

	// everything sampled mid-cycle, away from the driving edge
	always @(negedge clk) begin
		if (!rst_n) begin
			exp_q.delete();
			stall = 0;
			errors = 0;
			timeouts = 0;
		end else begin
			if (check_en && in_val) begin
				in_rec.name = test_name;
				in_rec.num = numerator;
				in_rec.den = denominator;
				in_rec.fac = factor;
				for (int k = 0; k < lanes; k++) begin
					in_rec.re[k*dw +: dw] = din_re[k];
					in_rec.im[k*dw +: dw] = din_im[k];
				end
				exp_q.push_back(in_rec);
			end
			if (check_en && out_val) begin
				if (exp_q.size() == 0) begin
					$display("output in test %s arrived with no input waiting for it",
						test_name);
					errors++;
				end else begin
					// results leave in input order
					out_rec = exp_q.pop_front();
					for (int k = 0; k < lanes; k++) begin
						compare_lane(out_rec, k, dout_re[k], dout_im[k]);
					end
				end
			end
			// queued inputs but the stream went quiet
			if (exp_q.size() != 0 && !out_val) begin
				stall++;
			end else begin
				stall = 0;
			end
			if (stall == stall_max) begin
				$display("timeout in test %s, %0d inputs never came out",
					test_name, exp_q.size());
				timeouts++;
			end
		end
		pending = exp_q.size();
	end

endmodule

`default_nettype wire

/* tb/tb_twdl_stage.sv */
`default_nettype none
`include "twdl_config.svh"

module tb_twdl_stage;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int lanes = `TWDL_LANES;
	localparam int dw = `TWDL_DATA_W;
	localparam int depth = `TWDL_FIFO_DEPTH;
	localparam int name_w = 96;
	localparam int nrows = 8;
	localparam int burst_len = 12;
	// small samples keep coefficient error inside the tolerance
	localparam int rand_bits = 10;
	localparam int poll_max = 100;
	localparam int wait_max = 400;
	localparam int kind_norm = 0;
	localparam int kind_early = 1;
	localparam int kind_ovf = 2;
	localparam logic [3:0] addr_unmapped = 4'hc;

	logic clk;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [3:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic in_val;
	fft_sample_pkg::data_t din_re [0:lanes-1];
	fft_sample_pkg::data_t din_im [0:lanes-1];
	logic out_val;
	fft_sample_pkg::data_t dout_re [0:lanes-1];
	fft_sample_pkg::data_t dout_im [0:lanes-1];

	// row currently applied, seen by the checker
	logic check_en;
	logic [name_w-1:0] cur_name;
	logic [11:0] cur_num;
	logic [11:0] cur_den;
	logic [2:0] cur_fac;
	int chk_pending;
	int chk_errors;
	int chk_timeouts;

	int errors;
	int timeouts;
	logic [15:0] lfsr;

	// stimulus table, lane 0 in the low bits of the lane vectors
	logic [name_w-1:0] row_name [nrows];
	int row_num [nrows];
	int row_den [nrows];
	int row_fac [nrows];
	int row_kind [nrows];
	logic [lanes*dw-1:0] row_re [nrows];
	logic [lanes*dw-1:0] row_im [nrows];

	tb_clkgen clk_i (
		.clk(clk),
		.rst_n(rst_n)
	);

	twdl_stage_top dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.in_val(in_val),
		.din_re(din_re),
		.din_im(din_im),
		.out_val(out_val),
		.dout_re(dout_re),
		.dout_im(dout_im)
	);

	twdl_checker #(
		.name_w(name_w)
	) chk_i (
		.clk(clk),
		.rst_n(rst_n),
		.check_en(check_en),
		.test_name(cur_name),
		.numerator(cur_num),
		.denominator(cur_den),
		.factor(cur_fac),
		.in_val(in_val),
		.din_re(din_re),
		.din_im(din_im),
		.out_val(out_val),
		.dout_re(dout_re),
		.dout_im(dout_im),
		.pending(chk_pending),
		.errors(chk_errors),
		.timeouts(chk_timeouts)
	);

	task automatic set_row(input int idx, input logic [name_w-1:0] name, input int n,
		input int d, input int f, input int kind,
		input logic [lanes*dw-1:0] re, input logic [lanes*dw-1:0] im);
		row_name[idx] = name;
		row_num[idx] = n;
		row_den[idx] = d;
		row_fac[idx] = f;
		row_kind[idx] = kind;
		row_re[idx] = re;
		row_im[idx] = im;
	endtask

	// lanes listed 4 down to 0
	task automatic fill_table();
		set_row(0, "rot_1_5", 1, 5, 5, kind_norm,
			{18'sd500, -18'sd400, 18'sd300, -18'sd200, 18'sd100},
			{-18'sd100, 18'sd200, -18'sd300, 18'sd400, -18'sd500});
		set_row(1, "rot_2_5", 2, 5, 5, kind_norm,
			{18'sd511, 18'sd511, 18'sd511, 18'sd511, 18'sd511},
			{18'sd0, 18'sd0, 18'sd0, 18'sd0, 18'sd0});
		set_row(2, "rot_3_16", 3, 16, 5, kind_norm,
			{-18'sd512, 18'sd17, -18'sd250, 18'sd333, -18'sd1},
			{18'sd77, -18'sd512, 18'sd250, 18'sd1, -18'sd333});
		set_row(3, "rot_1_4", 1, 4, 4, kind_norm,
			{18'sd0, 18'sd480, 18'sd0, -18'sd480, 18'sd131071},
			{18'sd480, 18'sd0, -18'sd480, 18'sd0, -18'sd131072});
		set_row(4, "radix2_1_8", 1, 8, 2, kind_norm,
			{18'sd300, 18'sd300, 18'sd300, 18'sd300, 18'sd300},
			{-18'sd300, -18'sd300, -18'sd300, -18'sd300, -18'sd300});
		set_row(5, "bypass_d3", 1, 3, 5, kind_norm,
			{18'sd131071, -18'sd131072, 18'sd65535, -18'sd1, 18'sd12345},
			{-18'sd131072, 18'sd131071, -18'sd65536, 18'sd1, -18'sd54321});
		set_row(6, "early_3_5", 3, 5, 5, kind_early,
			{18'sd123, -18'sd456, 18'sd78, -18'sd90, 18'sd321},
			{-18'sd210, 18'sd99, -18'sd500, 18'sd401, -18'sd64});
		set_row(7, "ovf_burst", 1, 8, 5, kind_ovf,
			{18'sd1, 18'sd2, 18'sd3, 18'sd4, 18'sd5},
			{18'sd5, 18'sd4, 18'sd3, 18'sd2, 18'sd1});
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1, Fibonacci form
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// one step per bit taken
	task automatic rand_value(output fft_sample_pkg::data_t v);
		logic [rand_bits-1:0] bits;
		bits = '0;
		for (int i = 0; i < rand_bits; i++) begin
			lfsr = lfsr_step(lfsr);
			bits = {bits[rand_bits-2:0], lfsr[0]};
		end
		v = $signed(bits);
	endtask

	task automatic expect_equal(input logic [name_w-1:0] name, input string what,
		input logic [31:0] exp_v, input logic [31:0] act_v);
		if (exp_v !== act_v) begin
			$display("[ERROR] %s %s: expected %0h, actual %0h", name, what, exp_v, act_v);
			errors++;
		end
	endtask

	// setup, access, then back to idle
	task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		rdata = prdata;
		err = pslverr;
		if (pready !== 1'b1) begin
			$display("pready was low in the access phase at address %0h", addr);
			errors++;
		end
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic err;
		apb_xfer(1'b1, addr, data, rd, err);
		if (err) begin
			$display("pslverr raised on a write to mapped address %0h", addr);
			errors++;
		end
	endtask

	task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
		logic err;
		apb_xfer(1'b0, addr, '0, data, err);
		if (err) begin
			$display("pslverr raised on a read from mapped address %0h", addr);
			errors++;
		end
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		while (rst_n !== 1'b1 && n < 20) begin
			@(posedge clk);
			n++;
		end
		if (rst_n !== 1'b1) begin
			$display("timeout, reset was never released");
			timeouts++;
		end
	endtask

	// poll status bit 0
	task automatic wait_ready(input logic [name_w-1:0] name);
		int n;
		logic [31:0] st;
		st = '0;
		n = 0;
		while (!st[0] && n < poll_max) begin
			reg_read(twdl_regs_pkg::addr_status, st);
			n++;
		end
		if (!st[0]) begin
			$display("timeout in test %s, coef_ready never came up", name);
			timeouts++;
		end
	endtask

	task automatic drive_sample(input logic [lanes*dw-1:0] re, input logic [lanes*dw-1:0] im);
		@(posedge clk);
		in_val <= 1'b1;
		for (int k = 0; k < lanes; k++) begin
			din_re[k] <= re[k*dw +: dw];
			din_im[k] <= im[k*dw +: dw];
		end
	endtask

	// table sample first, then random ones back to back
	task automatic send_burst(input int r, input int count);
		logic [lanes*dw-1:0] re;
		logic [lanes*dw-1:0] im;
		fft_sample_pkg::data_t v;
		drive_sample(row_re[r], row_im[r]);
		for (int n = 1; n < count; n++) begin
			for (int k = 0; k < lanes; k++) begin
				rand_value(v);
				re[k*dw +: dw] = v;
				rand_value(v);
				im[k*dw +: dw] = v;
			end
			drive_sample(re, im);
		end
		@(posedge clk);
		in_val <= 1'b0;
	endtask

	task automatic wait_drain(input logic [name_w-1:0] name);
		int n;
		n = 0;
		while (chk_pending != 0 && n < wait_max) begin
			@(posedge clk);
			n++;
		end
		if (chk_pending != 0) begin
			$display("timeout in test %s, %0d results still missing", name, chk_pending);
			timeouts++;
		end
	endtask

	task automatic run_row(input int r);
		logic [31:0] rd;
		logic [31:0] frac_word;
		frac_word = {4'h0, 12'(row_den[r]), 4'h0, 12'(row_num[r])};
		cur_name <= row_name[r];
		cur_num <= 12'(row_num[r]);
		cur_den <= 12'(row_den[r]);
		cur_fac <= 3'(row_fac[r]);
		reg_write(twdl_regs_pkg::addr_cfg_mode, 32'(row_fac[r]));
		reg_write(twdl_regs_pkg::addr_cfg_frac, frac_word);
		// early rows send straight into the recompute
		if (row_kind[r] != kind_early) begin
			wait_ready(row_name[r]);
		end
		send_burst(r, burst_len);
		wait_drain(row_name[r]);
		reg_read(twdl_regs_pkg::addr_cfg_frac, rd);
		expect_equal(row_name[r], "cfg_frac readback", frac_word, rd);
		reg_read(twdl_regs_pkg::addr_cfg_mode, rd);
		expect_equal(row_name[r], "cfg_mode readback", 32'(row_fac[r]), rd);
		// coef_ready set, no overflow
		reg_read(twdl_regs_pkg::addr_status, rd);
		expect_equal(row_name[r], "status", 32'h1, rd);
	endtask

	// burst beyond the buffer while W is being recomputed
	task automatic run_overflow(input int r);
		int got;
		int n;
		logic [31:0] st;
		check_en <= 1'b0;
		cur_name <= row_name[r];
		reg_write(twdl_regs_pkg::addr_cfg_frac,
			{4'h0, 12'(row_den[r]), 4'h0, 12'(row_num[r])});
		send_burst(r, depth + 2);
		got = 0;
		n = 0;
		while (got < depth && n < wait_max) begin
			@(negedge clk);
			if (out_val) got++;
			n++;
		end
		if (got < depth) begin
			$display("timeout in test %s, only %0d buffered samples came out", row_name[r], got);
			timeouts++;
		end
		// dropped samples must stay dropped
		repeat (20) begin
			@(negedge clk);
			if (out_val) got++;
		end
		expect_equal(row_name[r], "outputs kept", depth, got);
		reg_read(twdl_regs_pkg::addr_status, st);
		expect_equal(row_name[r], "status overflow bit", 1, st[1]);
		reg_read(twdl_regs_pkg::addr_status, st);
		expect_equal(row_name[r], "overflow after read", 0, st[1]);
		check_en <= 1'b1;
	endtask

	task automatic check_unmapped();
		logic [31:0] rd;
		logic err;
		apb_xfer(1'b0, addr_unmapped, '0, rd, err);
		expect_equal("apb_unmapped", "pslverr on read", 1, err);
		apb_xfer(1'b1, addr_unmapped, 32'h0123_4567, rd, err);
		expect_equal("apb_unmapped", "pslverr on write", 1, err);
	endtask

	initial begin
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		in_val = 1'b0;
		for (int k = 0; k < lanes; k++) begin
			din_re[k] = '0;
			din_im[k] = '0;
		end
		check_en = 1'b1;
		cur_name = '0;
		cur_num = 12'd0;
		cur_den = 12'd1;
		cur_fac = 3'd5;
		errors = 0;
		timeouts = 0;
		lfsr = 16'd7534;
		fill_table();
		wait_reset();
		for (int r = 0; r < nrows; r++) begin
			if (row_kind[r] == kind_ovf) begin
				run_overflow(r);
			end else begin
				run_row(r);
			end
		end
		check_unmapped();
		repeat (4) @(posedge clk);
		$display("errors %0d, timeouts %0d", errors + chk_errors, timeouts + chk_timeouts);
		if (errors + chk_errors == 0 && timeouts + chk_timeouts == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hdl
hdl/fft_sample_pkg.sv
hdl/twdl_regs_pkg.sv
hdl/twdl_apb_regs.sv
hdl/twdl_coef_gen.sv
hdl/twdl_sample_fifo.sv
hdl/twdl_rotator.sv
hdl/twdl_stage_top.sv
tb/tb_clkgen.sv
tb/twdl_checker.sv
tb/tb_twdl_stage.sv
